/* verilog/icache_geom_pkg.sv */
`default_nettype none

package icache_geom_pkg;

    localparam int addr_w   = 32;
    localparam int tag_w    = 20;   // pa[31:12]
    localparam int index_w  = 6;    // va[11:6]
    localparam int bank_w   = 2;    // va[5:4]
    localparam int line_w   = 512;
    localparam int bundle_w = 128;
    localparam int slots    = 4;

    // one address word seen by fetch and by cache operations
    typedef union packed {
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [bank_w-1:0]  bank;
            logic [1:0]         word;
            logic [1:0]         byte_off;
        } fetch;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [3:0]         rsvd;
            logic [1:0]         way;    // index invalidate target
        } cacop;
    } icache_addr_u;

endpackage

`default_nettype wire

/* verilog/icache_op_pkg.sv */
`default_nettype none

package icache_op_pkg;

    // codes 0 and 3 are ignored
    typedef enum logic [1:0] {
        cacop_idx_inv = 2'd1,   // clear way picked by va[1:0]
        cacop_hit_inv = 2'd2    // lookup, clear matching way
    } cacop_e;

    typedef enum logic [1:0] {
        st_run    = 2'd0,
        st_refill = 2'd1,   // waiting for l2_ack
        st_lookup = 2'd2    // hit invalidate compare cycle
    } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/icache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   fetch_adv,
    input  icache_geom_pkg::icache_addr_u          fetch_pc,
    input  logic                                   cacop_vld,
    input  logic [1:0]                             cacop_op,
    input  icache_geom_pkg::icache_addr_u          cacop_va,
    input  logic [icache_geom_pkg::tag_w-1:0]      ppn,
    input  icache_geom_pkg::icache_addr_u          s1_pc,
    input  logic                                   fill_en,
    input  logic [1:0]                             fill_way,
    input  logic                                   idx_inv_en,
    input  logic                                   hit_inv_en,
    output logic [NUM_WAYS-1:0]                    s1_valid_ways,
    output logic [NUM_WAYS-1:0][icache_geom_pkg::tag_w-1:0] s1_tags,
    output logic                                   lookup_hit,
    output logic [1:0]                             lookup_way
);

    localparam int sets = 2 ** icache_geom_pkg::index_w;

    logic [NUM_WAYS-1:0]                             valid [sets];
    logic [icache_geom_pkg::tag_w-1:0]               tag_mem [NUM_WAYS][sets];
    logic [NUM_WAYS-1:0]                             lk_valid;
    logic [NUM_WAYS-1:0][icache_geom_pkg::tag_w-1:0] lk_tags;
    logic [NUM_WAYS-1:0]                             lk_match;
    logic                                            lk_load;

    assign lk_load = cacop_vld && (cacop_op == icache_op_pkg::cacop_hit_inv);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < sets; s++) begin
                valid[s] <= '0;
            end
        end else begin
            if (fill_en) begin
                valid[s1_pc.fetch.index][fill_way] <= 1'b1;
            end
            if (idx_inv_en) begin
                valid[cacop_va.cacop.index][cacop_va.cacop.way] <= 1'b0;
            end
            if (hit_inv_en) begin
                valid[cacop_va.cacop.index][lookup_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][s1_pc.fetch.index] <= ppn;  // tag comes from the tlb
        end
    end

    // both read ports land one edge after their strobe
    always_ff @(posedge clk) begin
        if (fetch_adv) begin
            s1_valid_ways <= valid[fetch_pc.fetch.index];
            for (int w = 0; w < NUM_WAYS; w++) begin
                s1_tags[w] <= tag_mem[w][fetch_pc.fetch.index];
            end
        end
        if (lk_load) begin
            lk_valid <= valid[cacop_va.cacop.index];
            for (int w = 0; w < NUM_WAYS; w++) begin
                lk_tags[w] <= tag_mem[w][cacop_va.cacop.index];
            end
        end
    end

    always_comb begin
        lookup_way = 2'd0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            lk_match[w] = lk_valid[w] && (lk_tags[w] == cacop_va.cacop.tag);
            if (lk_match[w]) begin
                lookup_way = 2'(w);     // lowest matching way wins
            end
        end
    end

    assign lookup_hit = |lk_match;

endmodule

`default_nettype wire

/* verilog/icache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 fill_en,
    input  logic [1:0]                           fill_way,
    input  icache_geom_pkg::icache_addr_u        s1_pc,
    input  logic [icache_geom_pkg::line_w-1:0]   l2_data,
    input  logic [1:0]                           hit_way,
    output logic [icache_geom_pkg::bundle_w-1:0] rd_bank
);

    localparam int sets  = 2 ** icache_geom_pkg::index_w;
    localparam int banks = 2 ** icache_geom_pkg::bank_w;

    logic [banks-1:0][icache_geom_pkg::bundle_w-1:0] line_mem [NUM_WAYS][sets];
    logic [banks-1:0][icache_geom_pkg::bundle_w-1:0] fill_line;

    assign fill_line = l2_data;     // bank 0 in the low bits

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[fill_way][s1_pc.fetch.index] <= fill_line;
        end
    end

    // refill data bypasses the array so the bundle goes out on the ack edge
    always_comb begin
        if (fill_en) begin
            rd_bank = fill_line[s1_pc.fetch.bank];
        end else begin
            rd_bank = line_mem[hit_way][s1_pc.fetch.index][s1_pc.fetch.bank];
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_refill_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                s1_vld,
    input  logic                hit,
    input  logic [NUM_WAYS-1:0] s1_valid_ways,
    input  logic                cacop_vld,
    input  logic [1:0]          cacop_op,
    input  logic                l2_ack,
    input  logic                lookup_hit,
    output logic                fetch_adv,
    output logic                stage1_pause,
    output logic                l2_req,
    output logic                fill_en,
    output logic [1:0]          fill_way,
    output logic                idx_inv_en,
    output logic                hit_inv_en
);

    icache_op_pkg::ctrl_state_e state_q;
    icache_op_pkg::ctrl_state_e state_d;
    logic                       miss;
    logic                       run;
    logic [1:0]                 rr_q;

    assign miss = s1_vld && !hit;
    assign run  = (state_q == icache_op_pkg::st_run);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_op_pkg::st_run: begin
                if (miss) begin
                    state_d = icache_op_pkg::st_refill;
                end else if (cacop_vld && (cacop_op == icache_op_pkg::cacop_hit_inv)) begin
                    state_d = icache_op_pkg::st_lookup;
                end
            end
            icache_op_pkg::st_refill: begin
                if (l2_ack) begin
                    state_d = icache_op_pkg::st_run;
                end
            end
            default: state_d = icache_op_pkg::st_run;   // lookup is one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= icache_op_pkg::st_run;
        end else begin
            state_q <= state_d;
        end
    end

    assign stage1_pause = miss || !run || cacop_vld;
    assign fetch_adv    = !stage1_pause;
    assign l2_req       = (state_q == icache_op_pkg::st_refill);
    assign fill_en      = l2_req && l2_ack;
    assign idx_inv_en   = run && cacop_vld && (cacop_op == icache_op_pkg::cacop_idx_inv);
    assign hit_inv_en   = (state_q == icache_op_pkg::st_lookup) && lookup_hit;

    // lowest invalid way, else round robin
    always_comb begin
        fill_way = rr_q;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!s1_valid_ways[w]) begin
                fill_way = 2'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_q <= 2'd0;
        end else if (fill_en && (&s1_valid_ways)) begin
            rr_q <= (rr_q == 2'(NUM_WAYS - 1)) ? 2'd0 : rr_q + 2'd1;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_fetch_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_pipe #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   fetch_adv,
    input  logic                                   fetch_vld,
    input  icache_geom_pkg::icache_addr_u          fetch_pc,
    input  logic [icache_geom_pkg::slots-1:0]      slot_vld,
    input  logic [icache_geom_pkg::tag_w-1:0]      ppn,
    input  logic [NUM_WAYS-1:0]                    s1_valid_ways,
    input  logic [NUM_WAYS-1:0][icache_geom_pkg::tag_w-1:0] s1_tags,
    input  logic [icache_geom_pkg::bundle_w-1:0]   rd_bank,
    input  logic                                   l2_ack,
    output logic                                   s1_vld,
    output icache_geom_pkg::icache_addr_u          s1_pc,
    output logic                                   hit,
    output logic [1:0]                             hit_way,
    output logic [icache_geom_pkg::slots-1:0]      inst_vld,
    output logic [icache_geom_pkg::bundle_w-1:0]   inst_bundle,
    output icache_geom_pkg::icache_addr_u          pc_out
);

    logic [icache_geom_pkg::slots-1:0] s1_slots;
    logic [NUM_WAYS-1:0]               way_hit;
    logic                              done;

    // stage 1 empties on completion unless fetch_adv reloads it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
        end else if (fetch_adv) begin
            s1_vld <= fetch_vld;
        end else if (l2_ack) begin
            s1_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_adv) begin
            s1_pc    <= fetch_pc;
            s1_slots <= slot_vld;
        end
    end

    always_comb begin
        hit_way = 2'd0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            way_hit[w] = s1_valid_ways[w] && (s1_tags[w] == ppn);
            if (way_hit[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    assign hit  = s1_vld && (|way_hit);
    assign done = hit || (s1_vld && l2_ack);   // hit now or refill landing

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_vld <= '0;
        end else if (done) begin
            inst_vld <= s1_slots;
        end else begin
            inst_vld <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            inst_bundle <= rd_bank;
            pc_out      <= s1_pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 fetch_vld,
    input  icache_geom_pkg::icache_addr_u        fetch_pc,
    input  logic [icache_geom_pkg::slots-1:0]    slot_vld,
    input  logic [icache_geom_pkg::tag_w-1:0]    ppn,
    input  logic                                 cacop_vld,
    input  logic [1:0]                           cacop_op,
    input  icache_geom_pkg::icache_addr_u        cacop_va,
    input  logic                                 l2_ack,
    input  logic [icache_geom_pkg::line_w-1:0]   l2_data,
    output logic                                 stage1_pause,
    output logic                                 l2_req,
    output logic [icache_geom_pkg::addr_w-1:0]   l2_addr,
    output logic [icache_geom_pkg::slots-1:0]    inst_vld,
    output logic [icache_geom_pkg::bundle_w-1:0] inst_bundle,
    output icache_geom_pkg::icache_addr_u        pc_out
);

    localparam int off_w = icache_geom_pkg::addr_w - icache_geom_pkg::tag_w
                         - icache_geom_pkg::index_w;

    logic                                            fetch_adv;
    logic                                            s1_vld;
    icache_geom_pkg::icache_addr_u                   s1_pc;
    logic                                            hit;
    logic [1:0]                                      hit_way;
    logic [NUM_WAYS-1:0]                             s1_valid_ways;
    logic [NUM_WAYS-1:0][icache_geom_pkg::tag_w-1:0] s1_tags;
    logic                                            lookup_hit;
    logic                                            fill_en;
    logic [1:0]                                      fill_way;
    logic                                            idx_inv_en;
    logic                                            hit_inv_en;
    logic [icache_geom_pkg::bundle_w-1:0]            rd_bank;

    assign l2_addr = {ppn, s1_pc.fetch.index, {off_w{1'b0}}};  // line aligned

    icache_tag_array #(.NUM_WAYS(NUM_WAYS)) tag_array_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_adv     (fetch_adv),
        .fetch_pc      (fetch_pc),
        .cacop_vld     (cacop_vld),
        .cacop_op      (cacop_op),
        .cacop_va      (cacop_va),
        .ppn           (ppn),
        .s1_pc         (s1_pc),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .idx_inv_en    (idx_inv_en),
        .hit_inv_en    (hit_inv_en),
        .s1_valid_ways (s1_valid_ways),
        .s1_tags       (s1_tags),
        .lookup_hit    (lookup_hit),
        .lookup_way    ()
    );

    icache_data_array #(.NUM_WAYS(NUM_WAYS)) data_array_inst (
        .clk      (clk),
        .fill_en  (fill_en),
        .fill_way (fill_way),
        .s1_pc    (s1_pc),
        .l2_data  (l2_data),
        .hit_way  (hit_way),
        .rd_bank  (rd_bank)
    );

    icache_refill_ctrl #(.NUM_WAYS(NUM_WAYS)) refill_ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .s1_vld        (s1_vld),
        .hit           (hit),
        .s1_valid_ways (s1_valid_ways),
        .cacop_vld     (cacop_vld),
        .cacop_op      (cacop_op),
        .l2_ack        (l2_ack),
        .lookup_hit    (lookup_hit),
        .fetch_adv     (fetch_adv),
        .stage1_pause  (stage1_pause),
        .l2_req        (l2_req),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .idx_inv_en    (idx_inv_en),
        .hit_inv_en    (hit_inv_en)
    );

    icache_fetch_pipe #(.NUM_WAYS(NUM_WAYS)) fetch_pipe_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_adv     (fetch_adv),
        .fetch_vld     (fetch_vld),
        .fetch_pc      (fetch_pc),
        .slot_vld      (slot_vld),
        .ppn           (ppn),
        .s1_valid_ways (s1_valid_ways),
        .s1_tags       (s1_tags),
        .rd_bank       (rd_bank),
        .l2_ack        (l2_ack),
        .s1_vld        (s1_vld),
        .s1_pc         (s1_pc),
        .hit           (hit),
        .hit_way       (hit_way),
        .inst_vld      (inst_vld),
        .inst_bundle   (inst_bundle),
        .pc_out        (pc_out)
    );

endmodule

`default_nettype wire

/* bench/icache_tb_tasks.svh */
`ifndef icache_tb_tasks_svh
`define icache_tb_tasks_svh

task automatic present_fetch(input logic [31:0] pc, input logic [3:0] slots);
    @(posedge clk);
    fetch_vld <= 1'b1;
    fetch_pc  <= pc;
    slot_vld  <= slots;
    ppn       <= ppn_for_pc(pc);
endtask

// returns on the acceptance edge
task automatic wait_accept();
    int waited;
    waited = 0;
    @(negedge clk);
    while (stage1_pause && waited < 40) begin
        @(negedge clk);
        waited++;
    end
    assert (!stage1_pause) else begin
        failure_count++;
        $display("fetch of %h was never accepted, stage1_pause stayed high", fetch_pc);
    end
    @(posedge clk);
endtask

task automatic wait_bundle(output int cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (inst_vld == '0 && cycles < 30);
    assert (inst_vld != '0) else begin
        failure_count++;
        $display("no instruction bundle arrived within %0d cycles", cycles);
    end
endtask

task automatic compare_bundle(input logic [31:0] pc, input logic [3:0] slots);
    assert (inst_vld == slots) else begin
        mismatch_count++;
        $display("MISMATCH at %0t: inst_vld %b, expected %b", $time, inst_vld, slots);
    end
    assert (inst_bundle == expected_bundle(pc)) else begin
        mismatch_count++;
        $display("MISMATCH at %0t: bundle %h, expected %h", $time, inst_bundle,
                 expected_bundle(pc));
    end
    assert (pc_out == pc) else begin
        mismatch_count++;
        $display("MISMATCH at %0t: pc_out %h, expected %h", $time, pc_out, pc);
    end
endtask

task automatic fetch_and_compare(input logic [31:0] pc, input logic [3:0] slots,
                                 input logic expect_miss);
    int reqs_before;
    int cycles;
    reqs_before = l2_req_count;
    present_fetch(pc, slots);
    wait_accept();
    fetch_vld <= 1'b0;
    wait_bundle(cycles);
    compare_bundle(pc, slots);
    if (expect_miss) begin
        assert (l2_req_count == reqs_before + 1 && last_l2_addr == line_addr_of(pc)) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: pc %h wants one read of %h, saw %0d, last %h", $time,
                     pc, line_addr_of(pc), l2_req_count - reqs_before, last_l2_addr);
        end
    end else begin
        assert (l2_req_count == reqs_before && cycles == 2) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: pc %h wants a hit, saw %0d reads, %0d cycles", $time,
                     pc, l2_req_count - reqs_before, cycles);
        end
    end
endtask

task automatic issue_cacop(input logic [1:0] op, input logic [31:0] va);
    @(posedge clk);
    cacop_vld <= 1'b1;
    cacop_op  <= op;
    cacop_va  <= va;
    @(negedge clk);
    assert (stage1_pause) else begin
        mismatch_count++;
        $display("MISMATCH at %0t: stage1_pause low during a cache operation", $time);
    end
    @(posedge clk);
    cacop_vld <= 1'b0;
    repeat (2) @(posedge clk);  // va held through the lookup cycle
endtask

task automatic after_reset_test();
    @(negedge clk);
    assert (inst_vld == '0 && !l2_req && !stage1_pause) else begin
        mismatch_count++;
        $display("MISMATCH at %0t: outputs not idle after reset", $time);
    end
endtask

task automatic cold_miss_test();
    fetch_and_compare(32'h0040_1360, 4'hf, 1'b1);
endtask

task automatic bank_hit_test();
    for (int b = 0; b < 4; b++) begin
        fetch_and_compare(32'h0040_1340 + 32'(16 * b), 4'hf, 1'b0);
    end
endtask

task automatic pause_hold_test();
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    int          held;
    int          cycles;
    logic        seen_a;
    pc_a   = 32'h0080_2580;
    pc_b   = 32'h0080_25a0;    // same line keeps ppn valid for a
    held   = 0;
    seen_a = 1'b0;
    present_fetch(pc_a, 4'b0110);
    wait_accept();
    fetch_pc <= pc_b;
    slot_vld <= 4'b1000;
    do begin
        @(negedge clk);
        if (inst_vld != '0) begin
            compare_bundle(pc_a, 4'b0110);
            seen_a = 1'b1;
        end
        if (stage1_pause) begin
            held++;
        end
    end while (stage1_pause && held < 40);
    assert (seen_a && held > 0) else begin
        failure_count++;
        $display("second fetch was not held back until the first refill ended");
    end
    @(posedge clk);
    fetch_vld <= 1'b0;
    wait_bundle(cycles);
    compare_bundle(pc_b, 4'b1000);
endtask

task automatic eviction_test();
    logic [31:0] pcs [5];
    for (int k = 0; k < 5; k++) begin
        pcs[k] = {20'h10000 + 20'(k), 6'h15, 6'h00};
        fetch_and_compare(pcs[k], 4'hf, 1'b1);
    end
    for (int k = 1; k < 5; k++) begin
        fetch_and_compare(pcs[k], 4'hf, 1'b0);
    end
    fetch_and_compare(pcs[0], 4'hf, 1'b1);   // evicted by the fifth tag
endtask

task automatic index_inv_test();
    fetch_and_compare(32'h0123_4880, 4'hf, 1'b1);
    fetch_and_compare(32'h0567_8890, 4'hf, 1'b1);
    issue_cacop(icache_op_pkg::cacop_idx_inv, {20'h0, 6'h22, 4'h0, 2'd0});
    fetch_and_compare(32'h0123_4880, 4'hf, 1'b1);
    fetch_and_compare(32'h0567_8890, 4'hf, 1'b0);
endtask

task automatic hit_inv_test();
    fetch_and_compare(32'h0aaa_0a80, 4'hf, 1'b1);
    fetch_and_compare(32'h0bbb_0ab0, 4'hf, 1'b1);
    issue_cacop(icache_op_pkg::cacop_hit_inv, line_addr_of(32'h0aaa_0a80));
    fetch_and_compare(32'h0aaa_0a80, 4'hf, 1'b1);
    fetch_and_compare(32'h0bbb_0ab0, 4'hf, 1'b0);
    issue_cacop(icache_op_pkg::cacop_hit_inv, line_addr_of(32'h0ccc_0a80));  // absent tag
    fetch_and_compare(32'h0aaa_0a80, 4'hf, 1'b0);
    fetch_and_compare(32'h0bbb_0ab0, 4'hf, 1'b0);
endtask

`endif

/* bench/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int num_tests   = 6;
    localparam int half_period = 20;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 fetch_vld;
    icache_geom_pkg::icache_addr_u        fetch_pc;
    logic [icache_geom_pkg::slots-1:0]    slot_vld;
    logic [icache_geom_pkg::tag_w-1:0]    ppn;
    logic                                 cacop_vld;
    logic [1:0]                           cacop_op;
    icache_geom_pkg::icache_addr_u        cacop_va;
    logic                                 l2_ack;
    logic [icache_geom_pkg::line_w-1:0]   l2_data;
    logic                                 stage1_pause;
    logic                                 l2_req;
    logic [icache_geom_pkg::addr_w-1:0]   l2_addr;
    logic [icache_geom_pkg::slots-1:0]    inst_vld;
    logic [icache_geom_pkg::bundle_w-1:0] inst_bundle;
    icache_geom_pkg::icache_addr_u        pc_out;

    int          mismatch_count;
    int          failure_count;
    int          l2_req_count;
    logic [31:0] last_l2_addr;
    logic [15:0] lfsr_q;

    icache_top icache_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_vld    (fetch_vld),
        .fetch_pc     (fetch_pc),
        .slot_vld     (slot_vld),
        .ppn          (ppn),
        .cacop_vld    (cacop_vld),
        .cacop_op     (cacop_op),
        .cacop_va     (cacop_va),
        .l2_ack       (l2_ack),
        .l2_data      (l2_data),
        .stage1_pause (stage1_pause),
        .l2_req       (l2_req),
        .l2_addr      (l2_addr),
        .inst_vld     (inst_vld),
        .inst_bundle  (inst_bundle),
        .pc_out       (pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [19:0] ppn_for_pc(input logic [31:0] pc);
        return pc[31:12] ^ 20'h3c5a1;   // fixed page mapping
    endfunction

    function automatic logic [31:0] line_addr_of(input logic [31:0] pc);
        return {ppn_for_pc(pc), pc[11:6], 6'b0};
    endfunction

    // each word holds its own byte address
    function automatic logic [511:0] line_data(input logic [31:0] addr);
        logic [511:0] d;
        for (int k = 0; k < 16; k++) begin
            d[32*k +: 32] = addr + 32'(4 * k);
        end
        return d;
    endfunction

    function automatic logic [127:0] expected_bundle(input logic [31:0] pc);
        logic [127:0] b;
        for (int i = 0; i < 4; i++) begin
            b[32*i +: 32] = line_addr_of(pc) + {26'b0, pc[5:4], 4'b0} + 32'(4 * i);
        end
        return b;
    endfunction

    `include "icache_tb_tasks.svh"

    initial begin : l2_model
        int delay;
        l2_ack       = 1'b0;
        l2_data      = '0;
        l2_req_count = 0;
        last_l2_addr = '0;
        lfsr_q       = 16'd44;
        forever begin
            @(negedge clk);
            if (l2_req) begin
                l2_req_count++;
                last_l2_addr = l2_addr;
                delay = 1;
                for (int b = 0; b < 3; b++) begin
                    lfsr_q = lfsr_step(lfsr_q);
                    delay  = delay + (int'(lfsr_q[0]) << b);    // 1 to 8 cycles
                end
                repeat (delay - 1) @(posedge clk);
                @(posedge clk);
                l2_ack  <= 1'b1;
                l2_data <= line_data(last_l2_addr);
                @(posedge clk);
                l2_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(num_tests * 200 * 2 * half_period);
        $display("watchdog timeout: the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        fetch_vld      = 1'b0;
        fetch_pc       = '0;
        slot_vld       = '0;
        ppn            = '0;
        cacop_vld      = 1'b0;
        cacop_op       = 2'd0;
        cacop_va       = '0;
        mismatch_count = 0;
        failure_count  = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        after_reset_test();
        cold_miss_test();
        bank_hit_test();
        pause_hold_test();
        eviction_test();
        index_inv_test();
        hit_inv_test();
        $display("summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
verilog/icache_geom_pkg.sv
verilog/icache_op_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_refill_ctrl.sv
verilog/icache_fetch_pipe.sv
verilog/icache_top.sv
bench/icache_tb.sv
